// ==== ex_pkg.sv ====
package ex_pkg;

    // ########################################################################
    // widths
    // ########################################################################

    parameter int xlen_c = 64;

    // destination register index
    typedef logic [4:0] reg_addr_t;

    // ########################################################################
    // operation encodings
    // ########################################################################

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_mul,
        alu_divu,
        alu_remu
    } alu_op_t;

    typedef enum logic {op1_rs1, op1_pc} op1_sel_t;

    typedef enum logic {op2_rs2, op2_imm} op2_sel_t;

    // multicycle unit states
    typedef enum logic [1:0] {md_st_idle, md_st_busy, md_st_done} md_state_t;

endpackage

// ==== id_ex_reg.sv ====
`timescale 1ns/1ns
module id_ex_reg #(
    parameter int XLEN = ex_pkg::xlen_c
) (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                id_valid,
    input  ex_pkg::alu_op_t     op,
    input  ex_pkg::op1_sel_t    op1_sel,
    input  ex_pkg::op2_sel_t    op2_sel,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     pc,
    input  ex_pkg::reg_addr_t   rd_addr,
    input  logic                reg_wen,
    input  logic                exec_done,
    input  logic                ex_allowin,
    output logic                id_allowin,
    output logic                ex_valid,
    output logic                md_start,
    output ex_pkg::alu_op_t     ex_op,
    output ex_pkg::op1_sel_t    ex_op1_sel,
    output ex_pkg::op2_sel_t    ex_op2_sel,
    output logic [XLEN-1:0]     ex_rs1,
    output logic [XLEN-1:0]     ex_rs2,
    output logic [XLEN-1:0]     ex_imm,
    output logic [XLEN-1:0]     ex_pc,
    output ex_pkg::reg_addr_t   ex_rd_addr,
    output logic                ex_reg_wen
);

    logic occupied;
    logic id_fire;
    logic id_is_md;

    assign id_is_md = op inside {ex_pkg::alu_mul, ex_pkg::alu_divu, ex_pkg::alu_remu};

    // free, or the held op leaves this cycle
    assign id_allowin = !occupied || (exec_done && ex_allowin);
    assign ex_valid   = occupied && exec_done;
    assign id_fire    = id_valid && id_allowin;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            occupied <= 1'b0;
        end else if (id_allowin) begin
            occupied <= id_valid;
        end
    end

    // one cycle kick for the iterative unit, after the op is in place
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            md_start <= 1'b0;
        end else begin
            md_start <= id_fire && id_is_md;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (id_fire) begin
            ex_op      <= op;
            ex_op1_sel <= op1_sel;
            ex_op2_sel <= op2_sel;
            ex_rs1     <= rs1;
            ex_rs2     <= rs2;
            ex_imm     <= imm;
            ex_pc      <= pc;
            ex_rd_addr <= rd_addr;
            ex_reg_wen <= reg_wen;
        end
    end

endmodule

// ==== ex_alu.sv ====
`timescale 1ns/1ns
module ex_alu #(
    parameter int XLEN = ex_pkg::xlen_c
) (
    input  ex_pkg::alu_op_t     op,
    input  ex_pkg::op1_sel_t    op1_sel,
    input  ex_pkg::op2_sel_t    op2_sel,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     pc,
    output logic [XLEN-1:0]     alu_result
);

    localparam int SH_W = $clog2(XLEN);

    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic [SH_W-1:0] shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    // ########################################################################
    // operand select
    // ########################################################################

    assign opa = (op1_sel == ex_pkg::op1_pc) ? pc : rs1;
    assign opb = (op2_sel == ex_pkg::op2_imm) ? imm : rs2;

    assign shamt       = opb[SH_W-1:0];
    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    // ########################################################################
    // single cycle ops
    // ########################################################################

    always_comb begin
        case (op)
            ex_pkg::alu_add:  alu_result = opa + opb;
            ex_pkg::alu_sub:  alu_result = opa - opb;
            ex_pkg::alu_and:  alu_result = opa & opb;
            ex_pkg::alu_or:   alu_result = opa | opb;
            ex_pkg::alu_xor:  alu_result = opa ^ opb;
            ex_pkg::alu_sll:  alu_result = opa << shamt;
            ex_pkg::alu_srl:  alu_result = opa >> shamt;
            ex_pkg::alu_sra:  alu_result = $signed(opa) >>> shamt;
            ex_pkg::alu_slt:  alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            ex_pkg::alu_sltu: alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            // mul/div results come from the iterative unit
            default:          alu_result = '0;
        endcase
    end

endmodule

// ==== mul_div_unit.sv ====
`timescale 1ns/1ns
module mul_div_unit #(
    parameter int XLEN = ex_pkg::xlen_c
) (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                md_start,
    input  ex_pkg::alu_op_t     op,
    input  logic [XLEN-1:0]     src_a,
    input  logic [XLEN-1:0]     src_b,
    input  logic                md_ack,
    output logic [XLEN-1:0]     md_result,
    output logic                md_done
);

    localparam int CNT_W = $clog2(XLEN);

    ex_pkg::md_state_t  state;
    logic [CNT_W-1:0]   iter_cnt;
    logic               last_iter;
    logic               is_div;
    // acc: product or partial remainder
    // a: multiplicand or dividend/quotient
    // b: multiplier or divisor
    logic [XLEN-1:0]    acc_q;
    logic [XLEN-1:0]    a_q;
    logic [XLEN-1:0]    b_q;
    logic [XLEN+1:0]    trial;

    assign is_div    = (op == ex_pkg::alu_divu) || (op == ex_pkg::alu_remu);
    assign last_iter = (iter_cnt == CNT_W'(XLEN - 1));
    // shift in next dividend bit and try to subtract the divisor
    assign trial     = {1'b0, acc_q, a_q[XLEN-1]} - {2'b00, b_q};

    assign md_done   = (state == ex_pkg::md_st_done);
    assign md_result = (op == ex_pkg::alu_divu) ? a_q : acc_q;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            state    <= ex_pkg::md_st_idle;
            iter_cnt <= '0;
        end else begin
            case (state)
                ex_pkg::md_st_idle: begin
                    if (md_start) begin
                        state    <= ex_pkg::md_st_busy;
                        iter_cnt <= '0;
                    end
                end
                ex_pkg::md_st_busy: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (last_iter) begin
                        state <= ex_pkg::md_st_done;
                    end
                end
                ex_pkg::md_st_done: begin
                    if (md_ack) begin
                        state <= ex_pkg::md_st_idle;
                    end
                end
                default: state <= ex_pkg::md_st_idle;
            endcase
        end
    end

    // zero divisor never borrows, so quotient ends all ones and remainder = dividend
    always_ff @(posedge I_sys_clk) begin
        if (state == ex_pkg::md_st_idle && md_start) begin
            acc_q <= '0;
            a_q   <= src_a;
            b_q   <= src_b;
        end else if (state == ex_pkg::md_st_busy) begin
            if (is_div) begin
                if (!trial[XLEN+1]) begin
                    acc_q <= trial[XLEN-1:0];
                    a_q   <= {a_q[XLEN-2:0], 1'b1};
                end else begin
                    acc_q <= {acc_q[XLEN-2:0], a_q[XLEN-1]};
                    a_q   <= {a_q[XLEN-2:0], 1'b0};
                end
            end else begin
                if (b_q[0]) begin
                    acc_q <= acc_q + a_q;
                end
                a_q <= a_q << 1;
                b_q <= b_q >> 1;
            end
        end
    end

endmodule

// ==== ex_mem_reg.sv ====
`timescale 1ns/1ns
module ex_mem_reg #(
    parameter int XLEN = ex_pkg::xlen_c
) (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                ex_valid,
    input  logic [XLEN-1:0]     result,
    input  logic [XLEN-1:0]     pc,
    input  ex_pkg::reg_addr_t   rd_addr,
    input  logic                reg_wen,
    input  logic                mem_allowin,
    output logic                ex_allowin,
    output logic                mem_valid,
    output logic [XLEN-1:0]     mem_result,
    output logic [XLEN-1:0]     mem_pc,
    output ex_pkg::reg_addr_t   mem_rd_addr,
    output logic                mem_reg_wen
);

    // empty, or memory stage drains us this cycle
    assign ex_allowin = !mem_valid || mem_allowin;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mem_valid <= 1'b0;
        end else if (ex_allowin) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (ex_valid && ex_allowin) begin
            mem_result  <= result;
            mem_pc      <= pc;
            mem_rd_addr <= rd_addr;
            mem_reg_wen <= reg_wen;
        end
    end

endmodule

// ==== ex_stage_top.sv ====
`timescale 1ns/1ns
module ex_stage_top #(
    parameter int XLEN = ex_pkg::xlen_c
) (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                id_valid,
    input  ex_pkg::alu_op_t     op,
    input  ex_pkg::op1_sel_t    op1_sel,
    input  ex_pkg::op2_sel_t    op2_sel,
    input  logic [XLEN-1:0]     rs1,
    input  logic [XLEN-1:0]     rs2,
    input  logic [XLEN-1:0]     imm,
    input  logic [XLEN-1:0]     pc,
    input  ex_pkg::reg_addr_t   rd_addr,
    input  logic                reg_wen,
    output logic                id_allowin,
    input  logic                mem_allowin,
    output logic                mem_valid,
    output logic [XLEN-1:0]     mem_result,
    output ex_pkg::reg_addr_t   mem_rd_addr,
    output logic                mem_reg_wen,
    output logic [XLEN-1:0]     mem_pc
);

    ex_pkg::alu_op_t    ex_op;
    ex_pkg::op1_sel_t   ex_op1_sel;
    ex_pkg::op2_sel_t   ex_op2_sel;
    logic [XLEN-1:0]    ex_rs1;
    logic [XLEN-1:0]    ex_rs2;
    logic [XLEN-1:0]    ex_imm;
    logic [XLEN-1:0]    ex_pc;
    ex_pkg::reg_addr_t  ex_rd_addr;
    logic               ex_reg_wen;
    logic               ex_valid;
    logic               ex_allowin;
    logic               md_start;
    logic               md_done;
    logic               md_ack;
    logic               ex_is_md;
    logic               exec_done;
    logic [XLEN-1:0]    alu_result;
    logic [XLEN-1:0]    md_result;
    logic [XLEN-1:0]    ex_result;

    assign ex_is_md  = ex_op inside {ex_pkg::alu_mul, ex_pkg::alu_divu, ex_pkg::alu_remu};
    // alu is always ready, multicycle ops wait for the unit
    assign exec_done = !ex_is_md || md_done;
    // release the unit when its result moves into ex/mem
    assign md_ack    = ex_valid && ex_allowin;
    assign ex_result = ex_is_md ? md_result : alu_result;

    id_ex_reg #(.XLEN(XLEN)) i_id_ex_reg (
        .I_sys_clk(I_sys_clk), .I_rst(I_rst),
        .id_valid(id_valid), .op(op), .op1_sel(op1_sel), .op2_sel(op2_sel),
        .rs1(rs1), .rs2(rs2), .imm(imm), .pc(pc),
        .rd_addr(rd_addr), .reg_wen(reg_wen),
        .exec_done(exec_done), .ex_allowin(ex_allowin),
        .id_allowin(id_allowin), .ex_valid(ex_valid), .md_start(md_start),
        .ex_op(ex_op), .ex_op1_sel(ex_op1_sel), .ex_op2_sel(ex_op2_sel),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_imm(ex_imm), .ex_pc(ex_pc),
        .ex_rd_addr(ex_rd_addr), .ex_reg_wen(ex_reg_wen)
    );

    ex_alu #(.XLEN(XLEN)) i_ex_alu (
        .op(ex_op), .op1_sel(ex_op1_sel), .op2_sel(ex_op2_sel),
        .rs1(ex_rs1), .rs2(ex_rs2), .imm(ex_imm), .pc(ex_pc),
        .alu_result(alu_result)
    );

    // mul/div take rs1 and rs2 directly
    mul_div_unit #(.XLEN(XLEN)) i_mul_div_unit (
        .I_sys_clk(I_sys_clk), .I_rst(I_rst),
        .md_start(md_start), .op(ex_op), .src_a(ex_rs1), .src_b(ex_rs2),
        .md_ack(md_ack), .md_result(md_result), .md_done(md_done)
    );

    ex_mem_reg #(.XLEN(XLEN)) i_ex_mem_reg (
        .I_sys_clk(I_sys_clk), .I_rst(I_rst),
        .ex_valid(ex_valid), .result(ex_result), .pc(ex_pc),
        .rd_addr(ex_rd_addr), .reg_wen(ex_reg_wen), .mem_allowin(mem_allowin),
        .ex_allowin(ex_allowin), .mem_valid(mem_valid), .mem_result(mem_result),
        .mem_pc(mem_pc), .mem_rd_addr(mem_rd_addr), .mem_reg_wen(mem_reg_wen)
    );

endmodule

// ==== ex_stage_checker.sv ====
`timescale 1ns/1ns
module ex_stage_checker #(
    parameter int XLEN = ex_pkg::xlen_c
) (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                id_allowin,
    input  logic                occupied,
    input  logic                md_start,
    input  ex_pkg::md_state_t   md_state,
    input  logic                mem_valid,
    input  logic                mem_allowin,
    input  logic [XLEN-1:0]     mem_result,
    input  logic [XLEN-1:0]     mem_pc,
    input  ex_pkg::reg_addr_t   mem_rd_addr,
    input  logic                mem_reg_wen
);

    // stalled ex/mem must hold its payload
    mem_hold_a: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        (mem_valid && !mem_allowin) |=> (mem_valid && $stable(mem_result) && $stable(mem_pc)
            && $stable(mem_rd_addr) && $stable(mem_reg_wen)))
        else $error("ex/mem payload changed while stalled");

    md_start_idle_a: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        md_start |-> (md_state == ex_pkg::md_st_idle))
        else $error("multicycle start outside idle state");

    // full id/ex that cannot drain must refuse new ops
    id_block_a: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        (occupied && (md_start || md_state == ex_pkg::md_st_busy
            || (mem_valid && !mem_allowin))) |-> !id_allowin)
        else $error("id_allowin high while id/ex is blocked");

endmodule

bind ex_stage_top ex_stage_checker #(.XLEN(XLEN)) i_ex_stage_checker (
    .I_sys_clk(I_sys_clk), .I_rst(I_rst),
    .id_allowin(id_allowin), .occupied(i_id_ex_reg.occupied),
    .md_start(md_start), .md_state(i_mul_div_unit.state),
    .mem_valid(mem_valid), .mem_allowin(mem_allowin), .mem_result(mem_result),
    .mem_pc(mem_pc), .mem_rd_addr(mem_rd_addr), .mem_reg_wen(mem_reg_wen)
);

// ==== tb_ex_stage.sv ====
`timescale 1ns/1ns
module tb_ex_stage;

    localparam int XLEN    = ex_pkg::xlen_c;
    localparam int SH_W    = $clog2(XLEN);
    localparam int TIMEOUT = 500;

    typedef struct {
        logic [XLEN-1:0]    result;
        logic [XLEN-1:0]    pc;
        ex_pkg::reg_addr_t  rd_addr;
        logic               reg_wen;
        logic               chk_lat;
        int                 cycle;
    } exp_entry_t;

    logic               I_sys_clk = 1'b0;
    logic               I_rst;
    logic               id_valid;
    ex_pkg::alu_op_t    op;
    ex_pkg::op1_sel_t   op1_sel;
    ex_pkg::op2_sel_t   op2_sel;
    logic [XLEN-1:0]    rs1;
    logic [XLEN-1:0]    rs2;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    pc;
    ex_pkg::reg_addr_t  rd_addr;
    logic               reg_wen;
    logic               id_allowin;
    logic               mem_allowin;
    logic               mem_valid;
    logic [XLEN-1:0]    mem_result;
    ex_pkg::reg_addr_t  mem_rd_addr;
    logic               mem_reg_wen;
    logic [XLEN-1:0]    mem_pc;

    logic [31:0]        lfsr_q = 32'h72a9;
    logic [31:0]        bp_lfsr_q = 32'h72a9;
    logic               bp_on;
    logic               lat_mode;
    int                 errors = 0;
    int                 checked = 0;
    int                 cycle = 0;
    exp_entry_t         exp_q[$];

    always #50 I_sys_clk = ~I_sys_clk;

    always @(posedge I_sys_clk) cycle <= cycle + 1;

    ex_stage_top #(.XLEN(XLEN)) i_ex_stage_top (
        .I_sys_clk(I_sys_clk), .I_rst(I_rst), .id_valid(id_valid), .op(op),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .rs1(rs1), .rs2(rs2), .imm(imm), .pc(pc),
        .rd_addr(rd_addr), .reg_wen(reg_wen), .id_allowin(id_allowin),
        .mem_allowin(mem_allowin), .mem_valid(mem_valid), .mem_result(mem_result),
        .mem_rd_addr(mem_rd_addr), .mem_reg_wen(mem_reg_wen), .mem_pc(mem_pc)
    );

    // ########################################################################
    // random source and reference model
    // ########################################################################

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(ex_pkg::alu_op_t f_op,
            ex_pkg::op1_sel_t s1, ex_pkg::op2_sel_t s2, logic [XLEN-1:0] a_rs1,
            logic [XLEN-1:0] a_rs2, logic [XLEN-1:0] a_imm, logic [XLEN-1:0] a_pc);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = (s1 == ex_pkg::op1_pc) ? a_pc : a_rs1;
        b = (s2 == ex_pkg::op2_imm) ? a_imm : a_rs2;
        case (f_op)
            ex_pkg::alu_add:  return a + b;
            ex_pkg::alu_sub:  return a - b;
            ex_pkg::alu_and:  return a & b;
            ex_pkg::alu_or:   return a | b;
            ex_pkg::alu_xor:  return a ^ b;
            ex_pkg::alu_sll:  return a << b[SH_W-1:0];
            ex_pkg::alu_srl:  return a >> b[SH_W-1:0];
            ex_pkg::alu_sra:  return $signed(a) >>> b[SH_W-1:0];
            ex_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            ex_pkg::alu_sltu: return (a < b) ? 1 : 0;
            // multicycle ops always read rs1 and rs2
            ex_pkg::alu_mul:  return a_rs1 * a_rs2;
            ex_pkg::alu_divu: return (a_rs2 == 0) ? '1 : a_rs1 / a_rs2;
            default:          return (a_rs2 == 0) ? a_rs1 : a_rs1 % a_rs2;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
            input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ########################################################################
    // stimulus
    // ########################################################################

    // caller sits on a rising edge, returns on the transfer edge
    task automatic issue_random(input ex_pkg::alu_op_t f_op, input logic s1, input logic s2,
            input logic zero_div);
        int waited;
        waited = 0;
        id_valid <= 1'b1;
        op       <= f_op;
        op1_sel  <= ex_pkg::op1_sel_t'(s1);
        op2_sel  <= ex_pkg::op2_sel_t'(s2);
        rs1      <= rand_bits(XLEN);
        rs2      <= zero_div ? '0 : rand_bits(XLEN) >> rand_bits(SH_W);
        imm      <= rand_bits(XLEN);
        pc       <= rand_bits(XLEN - 2) << 2;
        rd_addr  <= rand_bits(5);
        reg_wen  <= rand_bits(1);
        @(negedge I_sys_clk);
        while (!id_allowin && waited < TIMEOUT) begin
            @(negedge I_sys_clk);
            waited++;
        end
        if (!id_allowin) begin
            $display("timeout: id_allowin stayed low for %0d cycles", TIMEOUT);
            errors++;
        end
        @(posedge I_sys_clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge I_sys_clk);
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge I_sys_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d operations never left the stage", exp_q.size());
            errors++;
        end
    endtask

    always @(posedge I_sys_clk) begin
        if (bp_on) begin
            bp_lfsr_q = lfsr_next(bp_lfsr_q);
            mem_allowin <= bp_lfsr_q[0];
        end else begin
            mem_allowin <= 1'b1;
        end
    end

    // ########################################################################
    // scoreboard, sampled between edges
    // ########################################################################

    always @(negedge I_sys_clk) begin
        exp_entry_t ent;
        if (!I_rst) begin
            if (mem_valid && mem_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("a result left the stage with no operation outstanding");
                    errors++;
                end else begin
                    ent = exp_q.pop_front();
                    checked++;
                    check_value("mem_result", mem_result, ent.result);
                    check_value("mem_pc", mem_pc, ent.pc);
                    check_value("mem_rd_addr", mem_rd_addr, ent.rd_addr);
                    check_value("mem_reg_wen", mem_reg_wen, ent.reg_wen);
                    if (ent.chk_lat) begin
                        check_value("latency", cycle - ent.cycle, 2);
                    end
                end
            end
            if (id_valid && id_allowin) begin
                ent.result  = expected_result(op, op1_sel, op2_sel, rs1, rs2, imm, pc);
                ent.pc      = pc;
                ent.rd_addr = rd_addr;
                ent.reg_wen = reg_wen;
                ent.chk_lat = lat_mode;
                ent.cycle   = cycle;
                exp_q.push_back(ent);
            end
        end
    end

    initial begin
        I_rst       = 1'b1;
        id_valid    = 1'b0;
        op          = ex_pkg::alu_add;
        op1_sel     = ex_pkg::op1_rs1;
        op2_sel     = ex_pkg::op2_rs2;
        rs1         = '0;
        rs2         = '0;
        imm         = '0;
        pc          = '0;
        rd_addr     = '0;
        reg_wen     = 1'b0;
        mem_allowin = 1'b1;
        bp_on       = 1'b0;
        lat_mode    = 1'b0;
        repeat (4) @(posedge I_sys_clk);
        I_rst <= 1'b0;
        @(negedge I_sys_clk);
        check_value("mem_valid", mem_valid, 1'b0);
        check_value("id_allowin", id_allowin, 1'b1);
        @(posedge I_sys_clk);

        // single cycle ops, every operand select
        lat_mode <= 1'b1;
        for (int k = 0; k < 10; k++) begin
            for (int s = 0; s < 4; s++) begin
                issue_random(ex_pkg::alu_op_t'(k), s[0], s[1], 1'b0);
            end
        end
        lat_mode <= 1'b0;

        // multicycle ops, some with a zero divisor
        for (int i = 0; i < 8; i++) begin
            issue_random(ex_pkg::alu_mul, rand_bits(1), rand_bits(1), 1'b0);
            issue_random(ex_pkg::alu_divu, rand_bits(1), rand_bits(1), i % 4 == 3);
            issue_random(ex_pkg::alu_remu, rand_bits(1), rand_bits(1), i % 4 == 1);
        end

        // random ops under back-pressure
        bp_on <= 1'b1;
        for (int i = 0; i < 60; i++) begin
            issue_random(ex_pkg::alu_op_t'(rand_bits(4) % 13), rand_bits(1), rand_bits(1),
                rand_bits(3) == 0);
        end
        bp_on <= 1'b0;

        // alu op right behind a multicycle op
        for (int i = 0; i < 12; i++) begin
            issue_random(ex_pkg::alu_op_t'(10 + i % 3), rand_bits(1), rand_bits(1), 1'b0);
            issue_random(ex_pkg::alu_op_t'(rand_bits(4) % 10), rand_bits(1), rand_bits(1),
                1'b0);
        end

        id_valid <= 1'b0;
        wait_drain();
        $display("checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
ex_pkg.sv
id_ex_reg.sv
ex_alu.sv
mul_div_unit.sv
ex_mem_reg.sv
ex_stage_top.sv
ex_stage_checker.sv
tb_ex_stage.sv
